/* cache_top.f */
+incdir+src
src/cache_pkg.sv
src/apb_if.sv
src/cache_ram.sv
src/cache_ctrl.sv
src/main_memory.sv
src/cache_top.sv
dv/cache_asserts.sv
dv/cache_tb.sv

/* dv/cache_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache assertions. APB protocol and processor handshake rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cache_asserts (
	input wire              clk,
	input wire              rst,
	input wire              req,
	input wire              busy,
	input wire              done,
	input wire              psel,
	input wire              penable,
	input wire              pwrite,
	input wire              pready,
	input cache_pkg::addr_t paddr,
	input cache_pkg::word_t pwdata
);

	// Failed assertions so far.
	int fail_count;

	initial begin
		fail_count = 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB link
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Access phase needs a selected slave.
	apb_enable_sel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
		else begin
			$error("APB penable high while psel is low");
			fail_count++;
		end

	// Transfer held with stable fields until pready.
	apb_hold: assert property (@(posedge clk) disable iff (rst)
		psel && penable && !pready |=> psel && penable
			&& $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else begin
			$error("APB transfer dropped or changed before pready");
			fail_count++;
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Processor handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	cpu_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
		else begin
			$error("done pulsed while busy was low");
			fail_count++;
		end

	// No new request while one is in flight.
	cpu_req_idle: assert property (@(posedge clk) disable iff (rst) req |-> !busy)
		else begin
			$error("req raised while busy was high");
			fail_count++;
		end

endmodule

bind cache_top cache_asserts i_cache_asserts (
	.clk, .rst, .req, .busy, .done,
	.psel    (mem_bus.psel),
	.penable (mem_bus.penable),
	.pwrite  (mem_bus.pwrite),
	.pready  (mem_bus.pready),
	.paddr   (mem_bus.paddr),
	.pwdata  (mem_bus.pwdata)
);

`default_nettype wire

/* dv/cache_golden.txt */
# Columns: op (R or W), address, write data, expected read data, expected hit flag.
# Address and data words are hex; the hit flag is 1 when the line holds the tag.
W 0005 11110005 00000000 0
R 0005 00000000 11110005 1
W 0045 22220045 00000000 0
R 0005 00000000 11110005 0
R 0005 00000000 11110005 1
R 0045 00000000 22220045 0
R 0045 00000000 22220045 1
W 0010 33330010 00000000 0
W 0110 44440110 00000000 0
R 0010 00000000 33330010 0
R 0110 00000000 44440110 0
R 0110 00000000 44440110 1
W 0110 55550110 00000000 1
R 0110 00000000 55550110 1
W 03ff 666603ff 00000000 0
R 03ff 00000000 666603ff 1
W 0005 77770005 00000000 0
R 0005 00000000 77770005 1
R 0045 00000000 22220045 0

/* dv/cache_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache testbench. Replays the golden operations against a line model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cache_defs.svh"

module cache_tb;

	localparam int TIMEOUT = 200;
	localparam int LINES   = 1 << `CACHE_INDEX_W;
	// Lookup, then respond.
	localparam int HIT_LAT = 2;
	// Lookup, APB setup, MEM_WAIT plus one access cycles, respond.
	localparam int MEM_LAT = 4 + `MEM_WAIT;

	logic              clk, rst, req, we, busy, done;
	cache_pkg::addr_t  addr;
	cache_pkg::word_t  wdata, rdata;
	logic [15:0]       access_count, miss_count;

	// Direct-mapped model of the tag array.
	logic              valid_m [LINES];
	cache_pkg::tag_t   tag_m [LINES];

	// Current golden line.
	logic [7:0]        op;
	cache_pkg::addr_t  g_addr;
	cache_pkg::word_t  g_wdata, g_rdata;
	int                g_hit;
	string             line;

	int  fd, ops, exp_miss;
	int  value_errors, timeouts, golden_errors, assert_fails;
	bit  timed_out;

	cache_top i_cache_top (
		.clk, .rst, .req, .we, .addr, .wdata,
		.busy, .done, .rdata, .access_count, .miss_count
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
		value_errors++;
	endtask

	// Outputs right after reset.
	task automatic check_reset_state();
		if (busy !== 1'b0) report_mismatch("busy", 0, 32'(busy));
		if (done !== 1'b0) report_mismatch("done", 0, 32'(done));
		if (access_count !== 16'd0) report_mismatch("access_count", 0, 32'(access_count));
		if (miss_count !== 16'd0) report_mismatch("miss_count", 0, 32'(miss_count));
	endtask

	// Returns at a falling edge with busy low.
	task automatic wait_idle();
		int k;
		k = 0;
		@(negedge clk);
		while (busy && k < TIMEOUT) begin
			@(negedge clk);
			k++;
		end
		if (busy) begin
			$display("Timeout at time %0t waiting for busy to drop", $time);
			timeouts++;
			timed_out = 1'b1;
		end
	endtask

	// Counts falling edges from the request edge to done.
	task automatic wait_done(output int lat);
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!done && lat < TIMEOUT);
		if (!done) begin
			$display("Timeout at time %0t waiting for done", $time);
			timeouts++;
			timed_out = 1'b1;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One processor request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task run_op();
		cache_pkg::index_t idx;
		cache_pkg::tag_t   tg;
		logic              model_hit, is_write;
		int                lat;
		idx       = g_addr[`CACHE_INDEX_W-1:0];
		tg        = g_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
		is_write  = (op == "W");
		model_hit = valid_m[idx] && (tag_m[idx] == tg);
		if (model_hit != (g_hit != 0)) begin
			$display("Golden hit flag for address %h disagrees with the line model", g_addr);
			golden_errors++;
		end
		wait_idle();
		if (timed_out) return;
		@(posedge clk);
		req   <= 1'b1;
		we    <= is_write;
		addr  <= g_addr;
		wdata <= g_wdata;
		// Request edge.
		@(posedge clk);
		req <= 1'b0;
		wait_done(lat);
		if (timed_out) return;
		ops++;
		if (!is_write && !model_hit) exp_miss++;
		// Misses and writes both allocate.
		valid_m[idx] = 1'b1;
		tag_m[idx]   = tg;
		if (!is_write && model_hit) begin
			if (lat != HIT_LAT) report_mismatch("done latency", HIT_LAT, lat);
		end else begin
			if (lat != MEM_LAT) report_mismatch("done latency", MEM_LAT, lat);
		end
		if (!is_write && rdata !== g_rdata) report_mismatch("rdata", g_rdata, rdata);
		if (miss_count !== 16'(exp_miss)) report_mismatch("miss_count", exp_miss, 32'(miss_count));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst   = 1'b1;
		req   = 1'b0;
		we    = 1'b0;
		addr  = '0;
		wdata = '0;
		ops = 0;
		exp_miss = 0;
		value_errors = 0;
		timeouts = 0;
		golden_errors = 0;
		timed_out = 1'b0;
		for (int i = 0; i < LINES; i++) begin
			valid_m[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// Clean state out of reset.
		@(negedge clk);
		check_reset_state();

		fd = $fopen("dv/cache_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file dv/cache_golden.txt");
			golden_errors++;
		end
		while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
			// Skip column notes and blank lines.
			if (line.len() < 2 || line.getc(0) == "#") continue;
			if ($sscanf(line, "%c %h %h %h %d", op, g_addr, g_wdata, g_rdata, g_hit) != 5) begin
				$display("Golden line could not be parsed: %s", line);
				golden_errors++;
				continue;
			end
			run_op();
		end
		if (fd != 0) $fclose(fd);

		// access_count moves on the edge after done.
		@(negedge clk);
		if (ops == 0) begin
			$display("No operation was run from the golden file");
			golden_errors++;
		end
		if (!timed_out) begin
			if (access_count !== 16'(ops)) report_mismatch("access_count", ops, 32'(access_count));
			if (miss_count !== 16'(exp_miss)) report_mismatch("miss_count", exp_miss, 32'(miss_count));
		end

		// A second reset clears the valid bits while main memory keeps its words.
		if (!timed_out && ops > 0) begin
			@(posedge clk);
			rst <= 1'b1;
			repeat (4) @(posedge clk);
			rst <= 1'b0;
			@(negedge clk);
			check_reset_state();
			for (int i = 0; i < LINES; i++) begin
				valid_m[i] = 1'b0;
			end
			exp_miss = 0;
			// The last address touched reads back its final word with a miss.
			g_rdata = (op == "W") ? g_wdata : g_rdata;
			op      = "R";
			g_wdata = '0;
			g_hit   = 0;
			run_op();
		end

		assert_fails = i_cache_top.i_cache_asserts.fail_count;
		$display("Errors: %0d value, %0d timeout, %0d golden, %0d assertion",
			value_errors, timeouts, golden_errors, assert_fails);
		if (value_errors + timeouts + golden_errors + assert_fails == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the cache simulation with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module cache_tb -f cache_top.f -o cache_sim &&
out=$(./obj_dir/cache_sim +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -qx "Test passed" && echo "Run passed" || { echo "Run failed"; exit 1; }

/* src/apb_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB link between the cache controller and main memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface apb_if;

	// Request side, driven by the master.
	logic              psel;
	logic              penable;
	logic              pwrite;
	cache_pkg::addr_t  paddr;
	cache_pkg::word_t  pwdata;

	// Response side, driven by the slave.
	cache_pkg::word_t  prdata;
	logic              pready;

	// Cache controller.
	modport master (
		output psel,
		output penable,
		output pwrite,
		output paddr,
		output pwdata,
		input  prdata,
		input  pready
	);

	// Main memory.
	modport slave (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready
	);

endinterface

`default_nettype wire

/* src/cache_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache controller. Direct-mapped lookup, write-through and allocate,
// APB master toward main memory, stall and performance counters.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cache_ctrl (
	input  wire                    clk,
	input  wire                    rst,
	// Processor port.
	input  wire                    req,
	input  wire                    we,
	input  cache_pkg::addr_t       addr,
	input  cache_pkg::word_t       wdata,
	output logic                   busy,
	output logic                   done,
	output cache_pkg::word_t       rdata,
	output logic [15:0]            access_count,
	output logic [15:0]            miss_count,
	// Tag array.
	output logic                   tag_en,
	output logic                   tag_we,
	output cache_pkg::index_t      tag_index,
	output cache_pkg::tag_entry_t  tag_wdata,
	input  cache_pkg::tag_entry_t  tag_rdata,
	// Data array.
	output logic                   data_en,
	output logic                   data_we,
	output cache_pkg::index_t      data_index,
	output cache_pkg::word_t       data_wdata,
	input  cache_pkg::word_t       data_rdata,
	// Main memory.
	apb_if.master                  mem
);

	localparam int IDX_W  = $bits(cache_pkg::index_t);
	localparam int ADDR_W = $bits(cache_pkg::addr_t);
	localparam int LINES  = 2 ** IDX_W;

	cache_pkg::ctrl_state_t state, state_next;

	// Latched request.
	logic              we_q;
	cache_pkg::addr_t  addr_q;
	cache_pkg::word_t  wdata_q;
	cache_pkg::word_t  rdata_q;

	// One valid bit per line.
	logic [LINES-1:0]  valid;

	cache_pkg::index_t req_idx, line_idx;
	cache_pkg::tag_t   line_tag;
	cache_pkg::word_t  read_word;
	logic              take, hit, fill;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address split and hit detection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign req_idx  = addr[IDX_W-1:0];
	assign line_idx = addr_q[IDX_W-1:0];
	assign line_tag = addr_q[ADDR_W-1:IDX_W];

	// Request accepted this edge.
	assign take = (state == cache_pkg::idle) && req;
	// RAM outputs are valid in lookup.
	assign hit  = valid[line_idx] && (tag_rdata.tag == line_tag);
	// Last APB cycle, line gets written.
	assign fill = (state == cache_pkg::apb_access) && mem.pready;

	// Cache word on a hit, memory word on a miss.
	assign read_word = (state == cache_pkg::lookup) ? data_rdata : mem.prdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// RAM control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read at the request edge, write on fill.
	assign tag_en     = take || fill;
	assign tag_we     = fill;
	assign tag_index  = (state == cache_pkg::idle) ? req_idx : line_idx;
	assign tag_wdata  = '{tag: line_tag};

	assign data_en    = take || fill;
	assign data_we    = fill;
	assign data_index = (state == cache_pkg::idle) ? req_idx : line_idx;
	// Writes allocate with the processor word.
	assign data_wdata = we_q ? wdata_q : mem.prdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB master
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign mem.psel    = (state == cache_pkg::apb_setup) || (state == cache_pkg::apb_access);
	assign mem.penable = (state == cache_pkg::apb_access);
	assign mem.pwrite  = we_q;
	assign mem.paddr   = addr_q;
	assign mem.pwdata  = wdata_q;

	// Processor handshake.
	assign busy  = (state != cache_pkg::idle);
	assign done  = (state == cache_pkg::respond);
	assign rdata = rdata_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_next = state;
		unique case (state)
			cache_pkg::idle:       if (req) state_next = cache_pkg::lookup;
			// Read hits answer at once, everything else goes to memory.
			cache_pkg::lookup:     state_next = (hit && !we_q) ? cache_pkg::respond
			                                                   : cache_pkg::apb_setup;
			cache_pkg::apb_setup:  state_next = cache_pkg::apb_access;
			cache_pkg::apb_access: if (mem.pready) state_next = cache_pkg::respond;
			cache_pkg::respond:    state_next = cache_pkg::idle;
			default:               state_next = cache_pkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= cache_pkg::idle;
			valid        <= '0;
			access_count <= '0;
			miss_count   <= '0;
		end else begin
			state <= state_next;
			// Line becomes valid once filled.
			if (fill) begin
				valid[line_idx] <= 1'b1;
			end
			// One access per completed request.
			if (state == cache_pkg::respond) begin
				access_count <= access_count + 16'd1;
			end
			// Only reads can miss.
			if ((state == cache_pkg::lookup) && !we_q && !hit) begin
				miss_count <= miss_count + 16'd1;
			end
		end
	end

	// Request fields and read data.
	always_ff @(posedge clk) begin
		if (take) begin
			we_q    <= we;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
		if (!we_q && (((state == cache_pkg::lookup) && hit) || fill)) begin
			rdata_q <= read_word;
		end
	end

endmodule

`default_nettype wire

/* src/cache_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache definitions. Address, data and index widths, plus the size
// and speed of main memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Word address width.
`define CACHE_ADDR_W 16
// Data word width.
`define CACHE_DATA_W 32
// Index width, 64 lines.
`define CACHE_INDEX_W 6

// Words held by main memory.
`define MEM_DEPTH 1024
// Wait states in the APB access phase.
`define MEM_WAIT 3

`endif

/* src/cache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache package. Word, address, index and tag types, controller state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

	// Basic words.
	typedef logic [`CACHE_DATA_W-1:0] word_t;
	typedef logic [`CACHE_ADDR_W-1:0] addr_t;

	// Address split: low bits pick the line, high bits are the tag.
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-1:0] tag_t;

	// One tag array entry. Valid bits live in the controller.
	typedef struct packed {
		tag_t tag;
	} tag_entry_t;

	// Controller FSM.
	typedef enum logic [2:0] {
		idle,
		lookup,
		apb_setup,
		apb_access,
		respond
	} ctrl_state_t;

endpackage

`default_nettype wire

/* src/cache_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache RAM. Single-port synchronous array, payload set by type.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cache_ram #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 64
) (
	input  wire               clk,
	input  wire               en,
	input  wire               we,
	input  cache_pkg::index_t index,
	input  payload_t          wdata,
	output payload_t          rdata
);

	// Storage, one entry per cache line.
	payload_t mem [DEPTH];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read and write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (en) begin
			// Write the new entry when asked.
			if (we) begin
				mem[index] <= wdata;
			end
			// Read returns the old entry on a write cycle.
			rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

/* src/cache_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory hierarchy top. Cache controller, tag and data RAMs, main memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cache_defs.svh"

module cache_top (
	input  wire              clk,
	input  wire              rst,
	input  wire              req,
	input  wire              we,
	input  cache_pkg::addr_t addr,
	input  cache_pkg::word_t wdata,
	output logic             busy,
	output logic             done,
	output cache_pkg::word_t rdata,
	output logic [15:0]      access_count,
	output logic [15:0]      miss_count
);

	localparam int LINES = 1 << `CACHE_INDEX_W;

	// Tag array wires.
	logic                  tag_en, tag_we;
	cache_pkg::index_t     tag_index;
	cache_pkg::tag_entry_t tag_wdata, tag_rdata;

	// Data array wires.
	logic                  data_en, data_we;
	cache_pkg::index_t     data_index;
	cache_pkg::word_t      data_wdata, data_rdata;

	// Link to main memory.
	apb_if mem_bus ();

	cache_ctrl i_ctrl (
		.clk, .rst, .req, .we, .addr, .wdata,
		.busy, .done, .rdata, .access_count, .miss_count,
		.tag_en, .tag_we, .tag_index, .tag_wdata, .tag_rdata,
		.data_en, .data_we, .data_index, .data_wdata, .data_rdata,
		.mem (mem_bus.master)
	);

	cache_ram #(.payload_t(cache_pkg::tag_entry_t), .DEPTH(LINES)) tag_ram (
		.clk, .en (tag_en), .we (tag_we), .index (tag_index),
		.wdata (tag_wdata), .rdata (tag_rdata)
	);

	cache_ram #(.payload_t(cache_pkg::word_t), .DEPTH(LINES)) data_ram (
		.clk, .en (data_en), .we (data_we), .index (data_index),
		.wdata (data_wdata), .rdata (data_rdata)
	);

	main_memory i_memory (
		.clk, .rst, .bus (mem_bus.slave)
	);

endmodule

`default_nettype wire

/* src/main_memory.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main memory. APB slave word array with fixed wait states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cache_defs.svh"

module main_memory (
	input  wire  clk,
	input  wire  rst,
	apb_if.slave bus
);

	localparam int MEM_AW = $clog2(`MEM_DEPTH);
	// Room for the full count, never zero wide.
	localparam int WAIT_W = $clog2(`MEM_WAIT + 2);
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`MEM_WAIT);

	// Word storage.
	cache_pkg::word_t  mem [`MEM_DEPTH];

	logic [MEM_AW-1:0] mem_idx;
	logic [WAIT_W-1:0] wait_cnt;

	// Upper address bits beyond the array are ignored.
	assign mem_idx = bus.paddr[MEM_AW-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wait states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Ready once MEM_WAIT access cycles have passed.
	assign bus.pready = bus.psel && bus.penable && (wait_cnt == WAIT_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= '0;
		end else if (bus.psel && bus.penable) begin
			// Restart for the next transfer.
			wait_cnt <= bus.pready ? '0 : wait_cnt + 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Array access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		// Read word fetched in setup, held through the access phase.
		if (bus.psel && !bus.penable && !bus.pwrite) begin
			bus.prdata <= mem[mem_idx];
		end
		// Write commits on the completing edge.
		if (bus.psel && bus.penable && bus.pready && bus.pwrite) begin
			mem[mem_idx] <= bus.pwdata;
		end
	end

endmodule

`default_nettype wire
